//--- hw/mmu_settings.svh
// -------------------------------------------------------------------
// Sv32 MMU settings
// address widths, TLB depth and page table constants
// -------------------------------------------------------------------
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// virtual and physical address widths
`define MMU_VLEN          32
`define MMU_PLEN          34

// page number and offset fields
`define MMU_PPN_W         22
`define MMU_VPN_W         10
`define MMU_PAGE_OFFSET_W 12
`define MMU_ASID_W        9

`define MMU_TLB_ENTRIES   4
`define MMU_PTE_SIZE      4

`endif

//--- hw/mmu_pkg.sv
// -------------------------------------------------------------------
// Sv32 MMU types
// page table entry, privilege, exception causes and walker encodings
// -------------------------------------------------------------------
`include "mmu_settings.svh"

package mmu_pkg;

  // Sv32 page table entry with the flags in the low byte
  typedef struct packed {
    logic [`MMU_PPN_W-1:0] ppn;
    logic [1:0]            rsw;
    logic                  d;
    logic                  a;
    logic                  g;
    logic                  u;
    logic                  x;
    logic                  w;
    logic                  r;
    logic                  v;
  } pte_t;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_lvl_e;

  // mcause codes of the data side
  typedef enum logic [3:0] {
    LD_ACCESS_FAULT  = 4'd5,
    ST_ACCESS_FAULT  = 4'd7,
    LOAD_PAGE_FAULT  = 4'd13,
    STORE_PAGE_FAULT = 4'd15
  } exc_cause_e;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_L1,
    WAIT_L0,
    DONE,
    FAULT
  } ptw_state_e;

  typedef enum logic [1:0] {
    FAULT_NONE,
    FAULT_PAGE,
    FAULT_ACCESS
  } ptw_fault_e;

endpackage

//--- hw/tlb_update_if.sv
// -------------------------------------------------------------------
// TLB fill channel from the page table walker to the TLB
// -------------------------------------------------------------------
`timescale 1ns/1ps
`include "mmu_settings.svh"

interface tlb_update_if
  import mmu_pkg::*;
();

  // single-cycle fill strobe
  logic                    valid;
  logic [2*`MMU_VPN_W-1:0] vpn;
  logic [`MMU_ASID_W-1:0]  asid;
  pte_t                    pte;
  logic                    superpage;

  modport ptw (output valid, vpn, asid, pte, superpage);
  modport tlb (input valid, vpn, asid, pte, superpage);

endinterface

//--- hw/tlb_entry.sv
// -------------------------------------------------------------------
// TLB entry
// holds one translation and compares it against the lookup address
// -------------------------------------------------------------------
`timescale 1ns/1ps
`include "mmu_settings.svh"

module tlb_entry
  import mmu_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  logic                    write_i,
  input  logic [2*`MMU_VPN_W-1:0] upd_vpn_i,
  input  logic [`MMU_ASID_W-1:0]  upd_asid_i,
  input  pte_t                    upd_pte_i,
  input  logic                    upd_superpage_i,
  input  logic [`MMU_VLEN-1:0]    lu_vaddr_i,
  input  logic [`MMU_ASID_W-1:0]  lu_asid_i,
  output logic                    match_o,
  output pte_t                    pte_o,
  output logic                    superpage_o
);

  logic                    valid_q;
  logic [2*`MMU_VPN_W-1:0] vpn_q;
  logic [`MMU_ASID_W-1:0]  asid_q;
  logic [`MMU_VPN_W-1:0]   lu_vpn1;
  logic [`MMU_VPN_W-1:0]   lu_vpn0;
  logic                    asid_ok;
  logic                    vpn_ok;

  always_ff @(posedge clk_i or negedge rst_ni) begin : valid_reg
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (write_i) begin
      valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin : tag_reg
    if (write_i) begin
      vpn_q       <= upd_vpn_i;
      asid_q      <= upd_asid_i;
      pte_o       <= upd_pte_i;
      superpage_o <= upd_superpage_i;
    end
  end

  assign lu_vpn1 = lu_vaddr_i[`MMU_VLEN-1 -: `MMU_VPN_W];
  assign lu_vpn0 = lu_vaddr_i[`MMU_PAGE_OFFSET_W +: `MMU_VPN_W];

  // global pages ignore the ASID
  assign asid_ok = pte_o.g || (asid_q == lu_asid_i);
  // a superpage covers all of vpn[0]
  assign vpn_ok  = (vpn_q[2*`MMU_VPN_W-1 -: `MMU_VPN_W] == lu_vpn1) &&
                   (superpage_o || (vpn_q[`MMU_VPN_W-1:0] == lu_vpn0));
  assign match_o = valid_q && asid_ok && vpn_ok;

endmodule

//--- hw/sv32_tlb.sv
// -------------------------------------------------------------------
// Sv32 data TLB
// fully associative, round-robin replacement, same-cycle lookup
// -------------------------------------------------------------------
`timescale 1ns/1ps
`include "mmu_settings.svh"

module sv32_tlb
  import mmu_pkg::*;
#(
  parameter int unsigned NrEntries = `MMU_TLB_ENTRIES
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   lu_access_i,
  input  logic [`MMU_VLEN-1:0]   lu_vaddr_i,
  input  logic [`MMU_ASID_W-1:0] lu_asid_i,
  tlb_update_if.tlb              upd,
  output logic                   lu_hit_o,
  output pte_t                   lu_pte_o,
  output logic                   lu_superpage_o
);

  localparam int unsigned IdxW = $clog2(NrEntries);

  logic [IdxW-1:0]      victim_q;
  logic [NrEntries-1:0] write_en;
  logic [NrEntries-1:0] match;
  logic [NrEntries-1:0] superpage;
  pte_t                 entry_pte [NrEntries];

  // -----------------------------------------------------------------
  // entries
  // -----------------------------------------------------------------
  for (genvar i = 0; i < NrEntries; i++) begin : gen_entry
    // one-hot write enable from the victim pointer
    assign write_en[i] = upd.valid && (victim_q == IdxW'(i));

    tlb_entry i_entry (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .flush_i        (flush_i),
      .write_i        (write_en[i]),
      .upd_vpn_i      (upd.vpn),
      .upd_asid_i     (upd.asid),
      .upd_pte_i      (upd.pte),
      .upd_superpage_i(upd.superpage),
      .lu_vaddr_i     (lu_vaddr_i),
      .lu_asid_i      (lu_asid_i),
      .match_o        (match[i]),
      .pte_o          (entry_pte[i]),
      .superpage_o    (superpage[i])
    );
  end

  // -----------------------------------------------------------------
  // replacement
  // -----------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : victim_ptr
    if (!rst_ni) begin
      victim_q <= '0;
    end else if (upd.valid) begin
      victim_q <= (victim_q == IdxW'(NrEntries - 1)) ? '0 : victim_q + IdxW'(1);
    end
  end

  // -----------------------------------------------------------------
  // hit selection
  // -----------------------------------------------------------------
  always_comb begin : hit_select
    lu_hit_o       = lu_access_i && (|match);
    lu_pte_o       = '0;
    lu_superpage_o = 1'b0;
    // at most one entry matches a given page
    for (int unsigned i = 0; i < NrEntries; i++) begin
      if (match[i]) begin
        lu_pte_o       = entry_pte[i];
        lu_superpage_o = superpage[i];
      end
    end
  end

endmodule

//--- hw/sv32_ptw.sv
// -------------------------------------------------------------------
// Sv32 page table walker
// two-level walk over a read-only Wishbone classic master, fills the TLB
// -------------------------------------------------------------------
`timescale 1ns/1ps
`include "mmu_settings.svh"

module sv32_ptw
  import mmu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   walk_req_i,
  input  logic [`MMU_VLEN-1:0]   vaddr_i,
  input  logic [`MMU_ASID_W-1:0] asid_i,
  input  logic [`MMU_PPN_W-1:0]  satp_ppn_i,
  tlb_update_if.ptw              upd,
  output ptw_fault_e             fault_o,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic [`MMU_PLEN-1:0]   wb_adr_o,
  input  logic [31:0]            wb_dat_i,
  input  logic                   wb_ack_i,
  input  logic                   wb_err_i
);

  localparam int unsigned PLen = `MMU_PLEN;

  ptw_state_e             state_q;
  ptw_fault_e             fault_q;
  logic                   cyc_q;
  logic [`MMU_PLEN-1:0]   adr_q;
  logic [`MMU_VLEN-1:0]   vaddr_q;
  logic [`MMU_ASID_W-1:0] asid_q;
  pte_t                   pte_q;
  logic                   superpage_q;
  pte_t                   rd_pte;
  logic                   rd_done;
  logic                   leaf;
  logic                   bad_pte;
  logic                   pg_fault_l1;
  logic                   pg_fault_l0;

  // table base plus the VPN slice scaled by the entry size
  function automatic logic [`MMU_PLEN-1:0] pte_addr(input logic [`MMU_PPN_W-1:0] ppn,
                                                    input logic [`MMU_VPN_W-1:0] vpn);
    return (PLen'(ppn) << `MMU_PAGE_OFFSET_W) + PLen'(vpn) * `MMU_PTE_SIZE;
  endfunction

  // -----------------------------------------------------------------
  // entry classification
  // -----------------------------------------------------------------
  assign rd_pte      = pte_t'(wb_dat_i);
  assign rd_done     = cyc_q && (wb_ack_i || wb_err_i);
  assign leaf        = rd_pte.r || rd_pte.x;
  // invalid, or the reserved w-without-r encoding
  assign bad_pte     = !rd_pte.v || (rd_pte.w && !rd_pte.r);
  // a superpage must be 4 MiB aligned
  assign pg_fault_l1 = bad_pte || (leaf && (|rd_pte.ppn[`MMU_VPN_W-1:0]));
  assign pg_fault_l0 = bad_pte || !leaf;

  // -----------------------------------------------------------------
  // walk FSM
  // -----------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm
    if (!rst_ni) begin
      state_q <= IDLE;
      fault_q <= FAULT_NONE;
      cyc_q   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (walk_req_i) begin
            state_q <= WAIT_L1;
            cyc_q   <= 1'b1;
          end
        end
        WAIT_L1: begin
          if (rd_done) begin
            cyc_q <= 1'b0;
            if (wb_err_i || pg_fault_l1) begin
              state_q <= FAULT;
              fault_q <= wb_err_i ? FAULT_ACCESS : FAULT_PAGE;
            end else begin
              state_q <= leaf ? DONE : WAIT_L0;
            end
          end
        end
        WAIT_L0: begin
          // bus idles one cycle between the two reads
          if (!cyc_q) begin
            cyc_q <= 1'b1;
          end else if (rd_done) begin
            cyc_q <= 1'b0;
            if (wb_err_i || pg_fault_l0) begin
              state_q <= FAULT;
              fault_q <= wb_err_i ? FAULT_ACCESS : FAULT_PAGE;
            end else begin
              state_q <= DONE;
            end
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin : walk_data
    if ((state_q == IDLE) && walk_req_i) begin
      vaddr_q <= vaddr_i;
      asid_q  <= asid_i;
      adr_q   <= pte_addr(satp_ppn_i, vaddr_i[`MMU_VLEN-1 -: `MMU_VPN_W]);
    end else if (rd_done) begin
      pte_q       <= rd_pte;
      superpage_q <= (state_q == WAIT_L1);
      // next-level address used only after a pointer entry
      adr_q       <= pte_addr(rd_pte.ppn, vaddr_q[`MMU_PAGE_OFFSET_W +: `MMU_VPN_W]);
    end
  end

  // -----------------------------------------------------------------
  // outputs
  // -----------------------------------------------------------------
  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_adr_o = adr_q;
  assign fault_o  = (state_q == FAULT) ? fault_q : FAULT_NONE;

  assign upd.valid     = (state_q == DONE);
  assign upd.vpn       = vaddr_q[`MMU_VLEN-1:`MMU_PAGE_OFFSET_W];
  assign upd.asid      = asid_q;
  assign upd.pte       = pte_q;
  assign upd.superpage = superpage_q;

endmodule

//--- hw/lsu_xlate.sv
// -------------------------------------------------------------------
// LSU translation stage
// accepts requests, registers the lookup and raises page/access faults
// -------------------------------------------------------------------
`timescale 1ns/1ps
`include "mmu_settings.svh"

module lsu_xlate
  import mmu_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 en_translation_i,
  input  priv_lvl_e            priv_lvl_i,
  input  logic                 sum_i,
  input  logic                 lsu_req_i,
  input  logic [`MMU_VLEN-1:0] lsu_vaddr_i,
  input  logic                 lsu_is_store_i,
  input  logic                 tlb_hit_i,
  input  pte_t                 tlb_pte_i,
  input  logic                 tlb_superpage_i,
  input  ptw_fault_e           ptw_fault_i,
  output logic                 walk_req_o,
  output logic                 lsu_dtlb_hit_o,
  output logic                 lsu_valid_o,
  output logic [`MMU_PLEN-1:0] lsu_paddr_o,
  output logic                 lsu_exc_valid_o,
  output exc_cause_e           lsu_exc_cause_o,
  output logic [`MMU_VLEN-1:0] lsu_exc_tval_o
);

  localparam int unsigned PLen  = `MMU_PLEN;
  // offset width inside a 4 MiB superpage
  localparam int unsigned SpOfs = `MMU_VPN_W + `MMU_PAGE_OFFSET_W;

  logic                 capture;
  logic                 valid_q;
  logic                 xlate_q;
  logic                 store_q;
  logic                 super_q;
  logic                 sum_q;
  priv_lvl_e            priv_q;
  logic [`MMU_VLEN-1:0] vaddr_q;
  pte_t                 pte_q;
  ptw_fault_e           fault_q;
  logic                 priv_err;
  logic                 page_fault;

  // -----------------------------------------------------------------
  // acceptance
  // -----------------------------------------------------------------
  assign lsu_dtlb_hit_o = en_translation_i ? tlb_hit_i : 1'b1;
  assign walk_req_o     = lsu_req_i && en_translation_i && !tlb_hit_i;
  // a walk fault completes the held request
  assign capture        = (lsu_req_i && lsu_dtlb_hit_o) || (ptw_fault_i != FAULT_NONE);

  always_ff @(posedge clk_i or negedge rst_ni) begin : valid_reg
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= capture;
    end
  end

  always_ff @(posedge clk_i) begin : stage_reg
    if (capture) begin
      xlate_q <= en_translation_i;
      vaddr_q <= lsu_vaddr_i;
      store_q <= lsu_is_store_i;
      priv_q  <= priv_lvl_i;
      sum_q   <= sum_i;
      pte_q   <= tlb_pte_i;
      super_q <= tlb_superpage_i;
      fault_q <= ptw_fault_i;
    end
  end

  // -----------------------------------------------------------------
  // physical address
  // -----------------------------------------------------------------
  always_comb begin : paddr_sel
    if (!xlate_q) begin
      lsu_paddr_o = PLen'(vaddr_q);
    end else if (super_q) begin
      lsu_paddr_o = {pte_q.ppn[`MMU_PPN_W-1:`MMU_VPN_W], vaddr_q[SpOfs-1:0]};
    end else begin
      lsu_paddr_o = {pte_q.ppn, vaddr_q[`MMU_PAGE_OFFSET_W-1:0]};
    end
  end

  // -----------------------------------------------------------------
  // exceptions
  // -----------------------------------------------------------------
  // S touches a U page only with SUM, U never touches an S page
  assign priv_err = ((priv_q == PRIV_S) && pte_q.u && !sum_q) ||
                    ((priv_q == PRIV_U) && !pte_q.u);

  always_comb begin : exc_check
    // all five permission checks raise the same page fault cause
    page_fault = priv_err ||
                 (!store_q && !pte_q.r) ||
                 (store_q && !pte_q.w) ||
                 !pte_q.a ||
                 (store_q && !pte_q.d);
    lsu_exc_cause_o = store_q ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
    if (fault_q == FAULT_ACCESS) begin
      lsu_exc_cause_o = store_q ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
    end
    lsu_exc_valid_o = valid_q && xlate_q && ((fault_q != FAULT_NONE) || page_fault);
  end

  assign lsu_valid_o    = valid_q;
  assign lsu_exc_tval_o = vaddr_q;

endmodule

//--- hw/sv32_mmu.sv
// -------------------------------------------------------------------
// Sv32 data MMU
// TLB, page table walker and translation stage
// -------------------------------------------------------------------
`timescale 1ns/1ps
`include "mmu_settings.svh"

module sv32_mmu
  import mmu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   en_translation_i,
  input  logic                   flush_tlb_i,
  input  logic [`MMU_PPN_W-1:0]  satp_ppn_i,
  input  logic [`MMU_ASID_W-1:0] asid_i,
  input  priv_lvl_e              priv_lvl_i,
  input  logic                   sum_i,
  // LSU side
  input  logic                   lsu_req_i,
  input  logic [`MMU_VLEN-1:0]   lsu_vaddr_i,
  input  logic                   lsu_is_store_i,
  output logic                   lsu_dtlb_hit_o,
  output logic                   lsu_valid_o,
  output logic [`MMU_PLEN-1:0]   lsu_paddr_o,
  output logic                   lsu_exc_valid_o,
  output exc_cause_e             lsu_exc_cause_o,
  output logic [`MMU_VLEN-1:0]   lsu_exc_tval_o,
  // Wishbone master, reads only
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic [`MMU_PLEN-1:0]   wb_adr_o,
  input  logic [31:0]            wb_dat_i,
  input  logic                   wb_ack_i,
  input  logic                   wb_err_i
);

  logic       tlb_hit;
  pte_t       tlb_pte;
  logic       tlb_superpage;
  logic       walk_req;
  ptw_fault_e ptw_fault;

  tlb_update_if upd_if ();

  sv32_tlb i_tlb (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_tlb_i),
    .lu_access_i   (lsu_req_i),
    .lu_vaddr_i    (lsu_vaddr_i),
    .lu_asid_i     (asid_i),
    .upd           (upd_if.tlb),
    .lu_hit_o      (tlb_hit),
    .lu_pte_o      (tlb_pte),
    .lu_superpage_o(tlb_superpage)
  );

  sv32_ptw i_ptw (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .walk_req_i(walk_req),
    .vaddr_i   (lsu_vaddr_i),
    .asid_i    (asid_i),
    .satp_ppn_i(satp_ppn_i),
    .upd       (upd_if.ptw),
    .fault_o   (ptw_fault),
    .wb_cyc_o  (wb_cyc_o),
    .wb_stb_o  (wb_stb_o),
    .wb_adr_o  (wb_adr_o),
    .wb_dat_i  (wb_dat_i),
    .wb_ack_i  (wb_ack_i),
    .wb_err_i  (wb_err_i)
  );

  lsu_xlate i_xlate (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .en_translation_i(en_translation_i),
    .priv_lvl_i      (priv_lvl_i),
    .sum_i           (sum_i),
    .lsu_req_i       (lsu_req_i),
    .lsu_vaddr_i     (lsu_vaddr_i),
    .lsu_is_store_i  (lsu_is_store_i),
    .tlb_hit_i       (tlb_hit),
    .tlb_pte_i       (tlb_pte),
    .tlb_superpage_i (tlb_superpage),
    .ptw_fault_i     (ptw_fault),
    .walk_req_o      (walk_req),
    .lsu_dtlb_hit_o  (lsu_dtlb_hit_o),
    .lsu_valid_o     (lsu_valid_o),
    .lsu_paddr_o     (lsu_paddr_o),
    .lsu_exc_valid_o (lsu_exc_valid_o),
    .lsu_exc_cause_o (lsu_exc_cause_o),
    .lsu_exc_tval_o  (lsu_exc_tval_o)
  );

endmodule

//--- bench/sv32_mmu_sva.sv
// --------------------------------------------------------------------
// Sv32 MMU port assertions
// Wishbone handshake rules and LSU result timing, bound to the top level
// --------------------------------------------------------------------
`timescale 1ns/1ps
`include "mmu_settings.svh"

module sv32_mmu_sva (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 lsu_req_i,
  input logic                 lsu_dtlb_hit_o,
  input logic                 lsu_valid_o,
  input logic                 wb_cyc_o,
  input logic                 wb_stb_o,
  input logic [`MMU_PLEN-1:0] wb_adr_o,
  input logic                 wb_ack_i,
  input logic                 wb_err_i
);

  // address and strobes held until the slave answers
  adr_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_cyc_o && !wb_ack_i && !wb_err_i) |=> (wb_cyc_o && wb_stb_o && $stable(wb_adr_o)))
    else $error("Wishbone cycle dropped or address changed before ack");

  cyc_drops: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_cyc_o && (wb_ack_i || wb_err_i)) |=> (!wb_cyc_o && !wb_stb_o))
    else $error("wb_cyc_o or wb_stb_o still high after ack or err");

  // the walker only reads while a held request misses the TLB
  walk_on_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_cyc_o |-> (lsu_req_i && !lsu_dtlb_hit_o))
    else $error("bus read without a pending TLB miss");

  // one-cycle result after acceptance
  valid_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lsu_req_i && lsu_dtlb_hit_o) |=> lsu_valid_o)
    else $error("accepted request gave no lsu_valid_o");

  // every result answers a request of the previous cycle
  valid_from_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_valid_o |-> $past(lsu_req_i))
    else $error("lsu_valid_o without a request in the previous cycle");

endmodule

bind sv32_mmu sv32_mmu_sva i_sva (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .lsu_req_i      (lsu_req_i),
  .lsu_dtlb_hit_o (lsu_dtlb_hit_o),
  .lsu_valid_o    (lsu_valid_o),
  .wb_cyc_o       (wb_cyc_o),
  .wb_stb_o       (wb_stb_o),
  .wb_adr_o       (wb_adr_o),
  .wb_ack_i       (wb_ack_i),
  .wb_err_i       (wb_err_i)
);

//--- bench/sv32_mmu_tb.sv
// --------------------------------------------------------------------
// Sv32 MMU testbench
// directed tests over a Wishbone page table memory with random ack delay
// --------------------------------------------------------------------
`timescale 1ns/1ps
`include "mmu_settings.svh"

module sv32_mmu_tb
  import mmu_pkg::*;
();

  localparam int unsigned NumTests   = 6;
  // cycles per test, enough for several walks at three wait states per read
  localparam int unsigned TestBudget = 300;
  localparam logic [21:0] RootPpn    = 22'h00080;
  // pte flag bits d a g u x w r v
  localparam logic [7:0]  FlPtr      = 8'h01;
  localparam logic [7:0]  FlRw       = 8'hc7;
  localparam logic [7:0]  FlRo       = 8'hc3;
  localparam logic [7:0]  FlUrw      = 8'hd7;
  localparam logic [7:0]  FlNoD      = 8'h47;
  localparam logic [7:0]  FlGrw      = 8'he7;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   en_translation_i;
  logic                   flush_tlb_i;
  logic [`MMU_PPN_W-1:0]  satp_ppn_i;
  logic [`MMU_ASID_W-1:0] asid_i;
  priv_lvl_e              priv_lvl_i;
  logic                   sum_i;
  logic                   lsu_req_i;
  logic [`MMU_VLEN-1:0]   lsu_vaddr_i;
  logic                   lsu_is_store_i;
  logic                   lsu_dtlb_hit_o;
  logic                   lsu_valid_o;
  logic [`MMU_PLEN-1:0]   lsu_paddr_o;
  logic                   lsu_exc_valid_o;
  exc_cause_e             lsu_exc_cause_o;
  logic [`MMU_VLEN-1:0]   lsu_exc_tval_o;
  logic                   wb_cyc_o;
  logic                   wb_stb_o;
  logic [`MMU_PLEN-1:0]   wb_adr_o;
  logic [31:0]            wb_dat_i;
  logic                   wb_ack_i;
  logic                   wb_err_i;

  logic [31:0]            mem [logic [33:0]];
  bit                     bad_adr [logic [33:0]];
  logic [33:0]            read_log [$];
  int unsigned            bus_reads;
  logic [31:0]            lfsr_q;
  bit                     busy;
  logic [1:0]             delay;

  // result of the last access
  logic [33:0]            res_paddr;
  logic                   res_exc;
  exc_cause_e             res_cause;
  logic [31:0]            res_tval;
  int unsigned            res_reads;
  logic                   res_hit;

  sv32_mmu i_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .en_translation_i(en_translation_i),
    .flush_tlb_i     (flush_tlb_i),
    .satp_ppn_i      (satp_ppn_i),
    .asid_i          (asid_i),
    .priv_lvl_i      (priv_lvl_i),
    .sum_i           (sum_i),
    .lsu_req_i       (lsu_req_i),
    .lsu_vaddr_i     (lsu_vaddr_i),
    .lsu_is_store_i  (lsu_is_store_i),
    .lsu_dtlb_hit_o  (lsu_dtlb_hit_o),
    .lsu_valid_o     (lsu_valid_o),
    .lsu_paddr_o     (lsu_paddr_o),
    .lsu_exc_valid_o (lsu_exc_valid_o),
    .lsu_exc_cause_o (lsu_exc_cause_o),
    .lsu_exc_tval_o  (lsu_exc_tval_o),
    .wb_cyc_o        (wb_cyc_o),
    .wb_stb_o        (wb_stb_o),
    .wb_adr_o        (wb_adr_o),
    .wb_dat_i        (wb_dat_i),
    .wb_ack_i        (wb_ack_i),
    .wb_err_i        (wb_err_i)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------
  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int unsigned n, output logic [1:0] bits);
    bits = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      bits   = {bits[0], lfsr_q[0]};
    end
  endtask

  function automatic logic [31:0] pte_word(input logic [21:0] ppn, input logic [7:0] flags);
    return {ppn, 2'b00, flags};
  endfunction

  // byte address of entry idx in the table at page ppn
  function automatic logic [33:0] table_slot(input logic [21:0] ppn, input logic [9:0] idx);
    return {ppn, 12'h000} + {22'h0, idx, 2'b00};
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic expect_eq(input string test, input string what,
                           input logic [33:0] exp, input logic [33:0] act);
    assert (exp === act) else begin
      stop_run($sformatf("** Error %s: %s expected 0x%0h, actual 0x%0h", test, what, exp, act));
    end
  endtask

  // a request that needs no bus read hits in its first cycle
  task automatic expect_ok(input string test, input logic [33:0] paddr, input int unsigned reads);
    expect_eq(test, "exception", 34'd0, 34'(res_exc));
    expect_eq(test, "paddr", paddr, res_paddr);
    expect_eq(test, "bus reads", 34'(reads), 34'(res_reads));
    expect_eq(test, "tlb hit", 34'(reads == 0), 34'(res_hit));
  endtask

  task automatic expect_fault(input string test, input logic [31:0] vaddr,
                              input exc_cause_e cause, input int unsigned reads);
    expect_eq(test, "exception", 34'd1, 34'(res_exc));
    expect_eq(test, "cause", 34'(cause), 34'(res_cause));
    expect_eq(test, "tval", 34'(vaddr), 34'(res_tval));
    expect_eq(test, "bus reads", 34'(reads), 34'(res_reads));
    expect_eq(test, "tlb hit", 34'(reads == 0), 34'(res_hit));
  endtask

  // present one request and hold it until lsu_valid_o
  task automatic access(input logic [31:0] vaddr, input logic store);
    int unsigned reads0;
    reads0         = bus_reads;
    lsu_vaddr_i    = vaddr;
    lsu_is_store_i = store;
    lsu_req_i      = 1'b1;
    @(negedge clk_i);
    res_hit = lsu_dtlb_hit_o;
    while (!lsu_valid_o) begin
      @(negedge clk_i);
    end
    res_paddr = lsu_paddr_o;
    res_exc   = lsu_exc_valid_o;
    res_cause = lsu_exc_cause_o;
    res_tval  = lsu_exc_tval_o;
    res_reads = bus_reads - reads0;
    lsu_req_i = 1'b0;
  endtask

  task automatic build_tables();
    mem[table_slot(RootPpn, 10'd1)]   = pte_word(22'h00090, FlPtr);
    mem[table_slot(22'h00090, 10'd1)] = pte_word(22'h12345, FlRw);
    mem[table_slot(RootPpn, 10'd2)]   = pte_word({12'h123, 10'h000}, FlRw);
    mem[table_slot(RootPpn, 10'd3)]   = pte_word({12'h123, 10'h001}, FlRo);
    mem[table_slot(RootPpn, 10'd4)]   = pte_word(22'h00091, FlPtr);
    mem[table_slot(22'h00091, 10'd0)] = pte_word(22'h00200, FlRo);
    mem[table_slot(22'h00091, 10'd1)] = pte_word(22'h00201, FlUrw);
    mem[table_slot(22'h00091, 10'd2)] = pte_word(22'h00202, FlNoD);
    mem[table_slot(RootPpn, 10'd6)]   = pte_word({12'h100, 10'h000}, FlGrw);
    // level-1 slot 5 answers with a bus error
    bad_adr[table_slot(RootPpn, 10'd5)] = 1'b1;
  endtask

  // --------------------------------------------------------------------
  // Wishbone page table memory
  // --------------------------------------------------------------------
  initial begin : wb_memory
    wb_dat_i  = '0;
    wb_ack_i  = 1'b0;
    wb_err_i  = 1'b0;
    bus_reads = 0;
    busy      = 1'b0;
    delay     = '0;
    lfsr_q    = 32'hbc8d_9e65;
    forever begin
      @(negedge clk_i);
      if (wb_ack_i || wb_err_i) begin
        wb_ack_i = 1'b0;
        wb_err_i = 1'b0;
        busy     = 1'b0;
      end else if (wb_cyc_o && wb_stb_o) begin
        if (!busy) begin
          busy = 1'b1;
          take_bits(2, delay);
        end
        if (delay == 2'd0) begin
          bus_reads++;
          read_log.push_back(wb_adr_o);
          if (bad_adr.exists(wb_adr_o)) begin
            wb_err_i = 1'b1;
          end else begin
            wb_dat_i = mem.exists(wb_adr_o) ? mem[wb_adr_o] : 32'h0;
            wb_ack_i = 1'b1;
          end
        end else begin
          delay = delay - 2'd1;
        end
      end
    end
  end

  // --------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------
  task automatic test_bare();
    en_translation_i = 1'b0;
    access(32'hdead_beef, 1'b0);
    expect_ok("bare", 34'h0_dead_beef, 0);
    access(32'h8000_0004, 1'b1);
    expect_ok("bare", 34'h0_8000_0004, 0);
    en_translation_i = 1'b1;
  endtask

  task automatic test_walk_hit();
    int unsigned log0;
    log0 = read_log.size();
    access(32'h0040_1234, 1'b0);
    expect_ok("walk_hit", {22'h12345, 12'h234}, 2);
    expect_eq("walk_hit", "level-1 address", table_slot(RootPpn, 10'd1), read_log[log0]);
    expect_eq("walk_hit", "level-0 address", table_slot(22'h00090, 10'd1), read_log[log0 + 1]);
    access(32'h0040_1234, 1'b0);
    expect_ok("walk_hit", {22'h12345, 12'h234}, 0);
  endtask

  task automatic test_superpage();
    access(32'h0080_5678, 1'b0);
    expect_ok("superpage", {12'h123, 22'h005678}, 1);
    access(32'h00c0_0010, 1'b0);
    expect_fault("superpage", 32'h00c0_0010, LOAD_PAGE_FAULT, 1);
  endtask

  task automatic test_permission();
    access(32'h0100_0000, 1'b1);
    expect_fault("permission", 32'h0100_0000, STORE_PAGE_FAULT, 2);
    access(32'h0100_1010, 1'b0);
    expect_fault("permission", 32'h0100_1010, LOAD_PAGE_FAULT, 2);
    sum_i = 1'b1;
    access(32'h0100_1010, 1'b0);
    expect_ok("permission", {22'h00201, 12'h010}, 0);
    sum_i = 1'b0;
    access(32'h0100_2000, 1'b1);
    expect_fault("permission", 32'h0100_2000, STORE_PAGE_FAULT, 2);
  endtask

  task automatic test_walk_fault();
    // no fill after a fault, so each repeat walks again
    repeat (2) begin
      access(32'h0100_3000, 1'b0);
      expect_fault("walk_fault", 32'h0100_3000, LOAD_PAGE_FAULT, 2);
    end
    repeat (2) begin
      access(32'h0140_0000, 1'b1);
      expect_fault("walk_fault", 32'h0140_0000, ST_ACCESS_FAULT, 1);
    end
  endtask

  task automatic test_asid_flush();
    access(32'h0040_1234, 1'b0);
    expect_eq("asid_flush", "paddr", {22'h12345, 12'h234}, res_paddr);
    access(32'h0040_1234, 1'b0);
    expect_ok("asid_flush", {22'h12345, 12'h234}, 0);
    access(32'h0180_0abc, 1'b0);
    expect_ok("asid_flush", {12'h100, 22'h000abc}, 1);
    asid_i = 9'h002;
    access(32'h0040_1234, 1'b0);
    expect_ok("asid_flush", {22'h12345, 12'h234}, 2);
    access(32'h0180_0abc, 1'b0);
    expect_ok("asid_flush", {12'h100, 22'h000abc}, 0);
    flush_tlb_i = 1'b1;
    @(negedge clk_i);
    flush_tlb_i = 1'b0;
    access(32'h0040_1234, 1'b0);
    expect_ok("asid_flush", {22'h12345, 12'h234}, 2);
    access(32'h0180_0abc, 1'b0);
    expect_ok("asid_flush", {12'h100, 22'h000abc}, 1);
  endtask

  initial begin : watchdog
    #((16 + NumTests * TestBudget) * 10);
    $display("timeout: the tests did not finish in the cycle budget");
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : stimulus
    rst_ni           = 1'b0;
    en_translation_i = 1'b0;
    flush_tlb_i      = 1'b0;
    satp_ppn_i       = RootPpn;
    asid_i           = 9'h001;
    priv_lvl_i       = PRIV_S;
    sum_i            = 1'b0;
    lsu_req_i        = 1'b0;
    lsu_vaddr_i      = '0;
    lsu_is_store_i   = 1'b0;
    build_tables();
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    expect_eq("reset", "lsu_valid_o", 34'd0, 34'(lsu_valid_o));
    expect_eq("reset", "wb_cyc_o", 34'd0, 34'(wb_cyc_o));
    expect_eq("reset", "wb_stb_o", 34'd0, 34'(wb_stb_o));
    test_bare();
    test_walk_hit();
    test_superpage();
    test_permission();
    test_walk_fault();
    test_asid_flush();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- sv32_mmu.f
+incdir+hw
hw/mmu_pkg.sv
hw/tlb_update_if.sv
hw/tlb_entry.sv
hw/sv32_tlb.sv
hw/sv32_ptw.sv
hw/lsu_xlate.sv
hw/sv32_mmu.sv
bench/sv32_mmu_sva.sv
bench/sv32_mmu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile the Sv32 MMU testbench with Verilator, run it and scan the log
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module sv32_mmu_tb -f sv32_mmu.f --Mdir "$build_dir" -o sim
if [ $? -ne 0 ]; then
  echo "run_sim: compile failed"
  exit 1
fi

"./$build_dir/sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "Simulation failed" "$log_file"; then
  echo "run_sim: FAILED"
  exit 1
elif [ $run_status -ne 0 ]; then
  echo "run_sim: simulator exited with status $run_status"
  exit 1
fi
echo "run_sim: PASSED"
exit 0
